// File: bench/state_stim.txt
# op id init value expected_state, all fields after op in hex
# DP lines run one per cycle, DPBURST opens a control add that overlaps the DP lines below it
NOP 1 0 0 0
NOP 2 0 0 0
NOP 3 0 0 0
NOP 5 0 0 0
NOP 6 0 0 0
DP 1 0 10 0
DP 1 0 5 10
DP 1 1 100 15
DP 2 1 abc 0
DP 3 0 1 0
DP 3 0 2 1
DP 3 0 3 3
DP 3 1 50 6
DP 3 0 1 50
CTRL 2 1 1000 abc
CTRL 2 0 234 1000
NOP 2 0 0 1234
CTRL 3 0 f 51
NOP 3 0 0 60
REAP 1 0 0 100
NOP 1 0 0 0
CTRL 6 1 7 0
DPBURST 6 0 3 7
DP 5 0 1 0
DP 5 0 1 1
DP 5 0 1 2
DP 5 0 1 3
DP 5 0 1 4
DP 5 0 1 5
DP 5 0 1 6
DP 5 0 1 7
DP 5 0 1 8
DP 5 0 1 9
NOP 6 0 0 a
REAP 5 0 0 a
NOP 5 0 0 0

// File: sim.f
hw/state_pkg.sv
hw/state_ctxt_fifo.sv
hw/state_req_proxy.sv
hw/state_control_mux.sv
hw/state_counter_core.sv
hw/state_apb_ctrl.sv
hw/state_counter_top.sv
bench/tb_state_counter.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sim.f --top-module tb_state_counter -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_state_counter.sv
`timescale 1ns/1ps

module tb_state_counter;

    localparam int    ID_WID           = 4;
    localparam int    NUM_TRANSACTIONS = 4;
    localparam int    CYCLES_PER_OP    = 50;
    localparam string STIM_FILE        = "bench/state_stim.txt";

    // One APB bus phase
    typedef struct packed {
        logic        sel;
        logic        en;
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] data;
    } apb_phase_t;

    logic                   clk;
    logic                   srst;
    logic [7:0]             paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    state_pkg::state_req_t  dp_req;
    state_pkg::state_resp_t dp_resp;

    string       op_q [$];
    logic [3:0]  id_q [$];
    logic        init_q [$];
    logic [31:0] val_q [$];
    logic [31:0] exp_q [$];
    apb_phase_t  apb_q [$];

    // Datapath expectations, slot 1 is due in the current cycle
    logic        pipe_vld [2];
    logic [31:0] pipe_exp [2];
    logic [31:0] prdata_smp;
    logic        cmd_open;
    logic [31:0] cmd_exp;
    logic        stim_ok;
    int          errors;
    int          cycles;
    int          limit;

    state_counter_top #(
        .ID_WID           (ID_WID),
        .NUM_TRANSACTIONS (NUM_TRANSACTIONS)
    ) UUT (
        .clk     (clk),
        .srst    (srst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .dp_req  (dp_req),
        .dp_resp (dp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic load_stim(output logic ok);
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [3:0]  id;
        logic        init;
        logic [31:0] val;
        logic [31:0] exp;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h", op, id, init, val, exp);
                    if (n == 5) begin
                        op_q.push_back(op);
                        id_q.push_back(id);
                        init_q.push_back(init);
                        val_q.push_back(val);
                        exp_q.push_back(exp);
                    end else begin
                        errors++;
                        $display("Stimulus line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One cycle: check the datapath ack due now, then drive datapath and APB
    task automatic tick(input logic go, input logic [3:0] id, input logic init,
                        input logic [31:0] val, input logic [31:0] exp);
        apb_phase_t ph;
        @(negedge clk);
        prdata_smp = prdata;
        // Access phase that just completed, zero wait states and no error
        if (psel && penable) begin
            check("pready", {31'h0, pready}, 32'h1);
            check("pslverr", {31'h0, pslverr}, 32'h0);
        end
        check("dp_resp.ack", {31'h0, dp_resp.ack}, {31'h0, pipe_vld[1]});
        if (pipe_vld[1]) begin
            check("dp_resp.state", dp_resp.state, pipe_exp[1]);
        end
        pipe_vld[1] = pipe_vld[0];
        pipe_exp[1] = pipe_exp[0];
        pipe_vld[0] = go;
        pipe_exp[0] = exp;
        dp_req        = '0;
        dp_req.req    = go;
        dp_req.ctxt   = state_pkg::UPDATE_CTXT_DATAPATH;
        dp_req.id     = {4'h0, id};
        dp_req.init   = init;
        dp_req.update = val;
        ph = '0;
        if (apb_q.size() > 0) begin
            ph = apb_q.pop_front();
        end
        psel    = ph.sel;
        penable = ph.en;
        pwrite  = ph.wr;
        paddr   = ph.addr;
        pwdata  = ph.data;
    endtask

    task automatic queue_write(input logic [7:0] addr, input logic [31:0] data);
        apb_q.push_back({1'b1, 1'b0, 1'b1, addr, data});
        apb_q.push_back({1'b1, 1'b1, 1'b1, addr, data});
    endtask

    task automatic drain();
        while (apb_q.size() > 0) begin
            tick(1'b0, 4'h0, 1'b0, 32'h0, 32'h0);
        end
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_q.push_back({1'b1, 1'b0, 1'b0, addr, 32'h0});
        apb_q.push_back({1'b1, 1'b1, 1'b0, addr, 32'h0});
        drain();
        // prdata of the access phase, seen at the start of the next cycle
        tick(1'b0, 4'h0, 1'b0, 32'h0, 32'h0);
        data = prdata_smp;
    endtask

    task automatic send_cmd(input state_pkg::update_ctxt_t ctxt, input logic [3:0] id,
                            input logic init, input logic [31:0] val,
                            input logic [31:0] exp, input logic twice);
        logic [31:0] word;
        // CMD word, id in 15:12, init in bit 8, context in 1:0
        word = {16'h0, id, 3'h0, init, 6'h0, ctxt};
        queue_write(state_pkg::REG_DATA, val);
        queue_write(state_pkg::REG_CMD, word);
        if (twice) begin
            queue_write(state_pkg::REG_CMD, word);
        end
        cmd_open = 1'b1;
        cmd_exp  = exp;
    endtask

    task automatic finish_cmd();
        logic [31:0] status;
        logic [31:0] result;
        drain();
        if (cmd_open) begin
            status = 32'h0;
            while (status[1] == 1'b0) begin
                apb_read(state_pkg::REG_STATUS, status);
            end
            check("STATUS.busy", {31'h0, status[0]}, 32'h0);
            apb_read(state_pkg::REG_RESULT, result);
            check("REG_RESULT", result, cmd_exp);
            cmd_open = 1'b0;
        end
    endtask

    task automatic run_op(input string op, input logic [3:0] id, input logic init,
                          input logic [31:0] val, input logic [31:0] exp);
        state_pkg::update_ctxt_t ctxt;
        ctxt = state_pkg::UPDATE_CTXT_CONTROL;
        if (op == "NOP") begin
            ctxt = state_pkg::UPDATE_CTXT_NOP;
        end else if (op == "REAP") begin
            ctxt = state_pkg::UPDATE_CTXT_REAP;
        end
        if (op == "DP") begin
            tick(1'b1, id, init, val, exp);
        end else if (op == "DPBURST" || op == "CTRL" || op == "NOP" || op == "REAP") begin
            finish_cmd();
            // A burst command stays open while the DP lines after it run
            send_cmd(ctxt, id, init, val, exp, op == "DPBURST");
            if (op != "DPBURST") begin
                finish_cmd();
            end
        end else begin
            errors++;
            $display("Unknown operation %s in the stimulus file", op);
        end
    endtask

    initial begin
        logic [31:0] status;
        srst       = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'h0;
        pwdata     = 32'h0;
        dp_req     = '0;
        pipe_vld   = '{1'b0, 1'b0};
        pipe_exp   = '{32'h0, 32'h0};
        prdata_smp = 32'h0;
        cmd_open   = 1'b0;
        cmd_exp    = 32'h0;
        errors     = 0;
        limit      = 0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            limit = CYCLES_PER_OP * op_q.size();
            repeat (3) @(posedge clk);
            @(negedge clk);
            srst = 1'b0;
            apb_read(state_pkg::REG_STATUS, status);
            check("REG_STATUS", status, 32'h0);
            for (int i = 0; i < op_q.size(); i++) begin
                run_op(op_q[i], id_q[i], init_q[i], val_q[i], exp_q[i]);
            end
            finish_cmd();
            repeat (2) tick(1'b0, 4'h0, 1'b0, 32'h0, 32'h0);
        end
        $display("Operations: %0d, errors: %0d", op_q.size(), errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_state_counter

// File: hw/state_counter_top.sv
`timescale 1ns/1ps

module state_counter_top #(
    parameter int ID_WID           = 4,
    parameter int NUM_TRANSACTIONS = 4
) (
    input  logic                             clk,
    input  logic                             srst,
    input  logic [state_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    input  state_pkg::state_req_t            dp_req,
    output state_pkg::state_resp_t           dp_resp
);

    state_pkg::state_req_t  ctrl_req;
    logic                   ctrl_rdy;
    state_pkg::state_resp_t ctrl_resp;
    state_pkg::state_req_t  core_req;
    logic                   core_rdy;
    state_pkg::state_resp_t core_resp;

    // Control plane
    state_apb_ctrl u_apb_ctrl (
        .clk       (clk),
        .srst      (srst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ctrl_req  (ctrl_req),
        .ctrl_rdy  (ctrl_rdy),
        .ctrl_resp (ctrl_resp)
    );

    state_control_mux #(
        .NUM_TRANSACTIONS (NUM_TRANSACTIONS)
    ) u_mux (
        .clk       (clk),
        .srst      (srst),
        .dp_req    (dp_req),
        .dp_resp   (dp_resp),
        .ctrl_req  (ctrl_req),
        .ctrl_rdy  (ctrl_rdy),
        .ctrl_resp (ctrl_resp),
        .core_req  (core_req),
        .core_rdy  (core_rdy),
        .core_resp (core_resp)
    );

    // Counter bank, 2**ID_WID entries
    state_counter_core #(
        .ID_WID (ID_WID)
    ) u_core (
        .clk  (clk),
        .srst (srst),
        .req  (core_req),
        .rdy  (core_rdy),
        .resp (core_resp)
    );

endmodule : state_counter_top

// File: hw/state_apb_ctrl.sv
`timescale 1ns/1ps

module state_apb_ctrl (
    input  logic                            clk,
    input  logic                            srst,
    input  logic [state_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    output state_pkg::state_req_t           ctrl_req,
    input  logic                            ctrl_rdy,
    input  state_pkg::state_resp_t          ctrl_resp
);

    logic                            wr_en;
    logic                            cmd_wr;
    logic                            req_q;
    logic                            busy;
    logic                            done;
    state_pkg::update_ctxt_t         cmd_ctxt;
    logic [3:0]                      cmd_id;
    logic                            cmd_init;
    logic [state_pkg::UPDATE_W-1:0]  data_q;
    logic [state_pkg::STATE_W-1:0]   result_q;

    // Zero wait states, no error response
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_en  = psel && penable && pwrite;
    // CMD is dropped while a command is open
    assign cmd_wr = wr_en && (paddr == state_pkg::REG_CMD) && !busy;

    always_ff @(posedge clk) begin
        if (srst) begin
            req_q <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else if (cmd_wr) begin
            req_q <= 1'b1;
            busy  <= 1'b1;
            done  <= 1'b0;
        end else begin
            if (req_q && ctrl_rdy) begin
                req_q <= 1'b0;
            end
            if (ctrl_resp.ack) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            cmd_ctxt <= state_pkg::update_ctxt_t'(pwdata[1:0]);
            cmd_init <= pwdata[8];
            cmd_id   <= pwdata[15:12];
        end
        if (wr_en && (paddr == state_pkg::REG_DATA)) begin
            data_q <= pwdata;
        end
        if (ctrl_resp.ack) begin
            result_q <= ctrl_resp.state;
        end
    end

    always_comb begin
        ctrl_req        = '0;
        ctrl_req.req    = req_q;
        ctrl_req.ctxt   = cmd_ctxt;
        ctrl_req.id[3:0] = cmd_id;
        ctrl_req.init   = cmd_init;
        ctrl_req.update = data_q;
    end

    // Read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            state_pkg::REG_CMD:    prdata = {16'h0, cmd_id, 3'b0, cmd_init, 6'b0, cmd_ctxt};
            state_pkg::REG_DATA:   prdata = data_q;
            state_pkg::REG_RESULT: prdata = result_q;
            state_pkg::REG_STATUS: prdata = {30'b0, done, busy};
            default:               prdata = '0;
        endcase
    end

endmodule : state_apb_ctrl

// File: hw/state_counter_core.sv
`timescale 1ns/1ps

module state_counter_core #(
    parameter int ID_WID = 4
) (
    input  logic                   clk,
    input  logic                   srst,
    input  state_pkg::state_req_t  req,
    output logic                   rdy,
    output state_pkg::state_resp_t resp
);

    localparam int NUM_IDS = 2 ** ID_WID;

    logic [state_pkg::STATE_W-1:0] counters [NUM_IDS];

    logic                          accept;
    logic                          s1_vld;
    state_pkg::state_req_t         s1_req;
    logic [ID_WID-1:0]             s1_id;
    logic [state_pkg::STATE_W-1:0] s1_rd;
    logic                          s2_vld;
    state_pkg::state_req_t         s2_req;
    logic [ID_WID-1:0]             s2_id;
    logic [state_pkg::STATE_W-1:0] s2_old;
    logic [state_pkg::STATE_W-1:0] s2_new;

    // One request per cycle outside reset
    assign rdy    = !srst;
    assign accept = req.req && rdy;

    assign s1_id = s1_req.id[ID_WID-1:0];
    assign s2_id = s2_req.id[ID_WID-1:0];

    // Stage 1 read, bypass the write that stage 2 does this cycle
    assign s1_rd = (s2_vld && (s2_id == s1_id)) ? s2_new : counters[s1_id];

    always_comb begin
        s2_new = s2_old;
        case (s2_req.ctxt)
            state_pkg::UPDATE_CTXT_DATAPATH,
            state_pkg::UPDATE_CTXT_CONTROL: begin
                s2_new = s2_req.init ? s2_req.update : s2_old + s2_req.update;
            end
            state_pkg::UPDATE_CTXT_REAP: begin
                s2_new = '0;
            end
            default: begin
                s2_new = s2_old;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            s1_vld <= accept;
            s2_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        s1_req <= req;
        s2_req <= s1_req;
        s2_old <= s1_rd;
    end

    // Write back at the end of stage 2
    always_ff @(posedge clk) begin
        if (srst) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                counters[i] <= '0;
            end
        end else if (s2_vld) begin
            counters[s2_id] <= s2_new;
        end
    end

    always_comb begin
        resp.ack   = s2_vld;
        resp.state = s2_old;
    end

endmodule : state_counter_core

// File: hw/state_control_mux.sv
`timescale 1ns/1ps

module state_control_mux #(
    parameter int NUM_TRANSACTIONS = 4
) (
    input  logic                   clk,
    input  logic                   srst,
    input  state_pkg::state_req_t  dp_req,
    output state_pkg::state_resp_t dp_resp,
    input  state_pkg::state_req_t  ctrl_req,
    output logic                   ctrl_rdy,
    output state_pkg::state_resp_t ctrl_resp,
    output state_pkg::state_req_t  core_req,
    input  logic                   core_rdy,
    input  state_pkg::state_resp_t core_resp
);

    state_pkg::state_req_t prx_req;
    logic                  prx_rdy;
    logic                  ctrl_sel;
    logic                  ack_to_ctrl;
    logic                  fifo_empty;
    logic                  fifo_sel;

    // Control requests are held here, at most one open
    state_req_proxy u_proxy (
        .clk     (clk),
        .srst    (srst),
        .in_req  (ctrl_req),
        .in_rdy  (ctrl_rdy),
        .out_req (prx_req),
        .out_rdy (prx_rdy),
        .out_ack (ack_to_ctrl)
    );

    // Datapath has strict priority
    assign ctrl_sel = !dp_req.req;
    assign prx_rdy  = ctrl_sel && core_rdy;
    assign core_req = ctrl_sel ? prx_req : dp_req;

    // Owner of each open transaction, in acceptance order
    state_ctxt_fifo #(
        .DEPTH (NUM_TRANSACTIONS)
    ) u_ctxt_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (core_req.req && core_rdy),
        .wr_data (ctrl_sel),
        .rd      (core_resp.ack),
        .rd_data (fifo_sel),
        .empty   (fifo_empty)
    );

    assign ack_to_ctrl = core_resp.ack && !fifo_empty && fifo_sel;

    // State goes to both sides, only the owner sees ack
    always_comb begin
        dp_resp.ack     = core_resp.ack && !ack_to_ctrl;
        dp_resp.state   = core_resp.state;
        ctrl_resp.ack   = ack_to_ctrl;
        ctrl_resp.state = core_resp.state;
    end

endmodule : state_control_mux

// File: hw/state_req_proxy.sv
`timescale 1ns/1ps

module state_req_proxy (
    input  logic                  clk,
    input  logic                  srst,
    input  state_pkg::state_req_t in_req,
    output logic                  in_rdy,
    output state_pkg::state_req_t out_req,
    input  logic                  out_rdy,
    input  logic                  out_ack
);

    logic                  pending;
    logic                  in_progress;
    logic                  accept;
    state_pkg::state_req_t held;

    // One transaction at a time, from acceptance until its ack
    assign in_rdy = !pending && !in_progress;
    assign accept = in_req.req && in_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (out_rdy) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            in_progress <= 1'b0;
        end else if (pending && out_rdy) begin
            in_progress <= 1'b1;
        end else if (out_ack) begin
            in_progress <= 1'b0;
        end
    end

    // Request fields held for the downstream side
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= in_req;
        end
    end

    always_comb begin
        out_req     = held;
        out_req.req = pending;
    end

endmodule : state_req_proxy

// File: hw/state_ctxt_fifo.sv
`timescale 1ns/1ps

module state_ctxt_fifo #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic srst,
    input  logic wr,
    input  logic wr_data,
    input  logic rd,
    output logic rd_data,
    output logic empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push = wr;
    // Never pop past the last entry
    assign pop  = rd && !empty;

    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : state_ctxt_fifo

// File: hw/state_pkg.sv
package state_pkg;

    // Field widths of a request and response
    localparam int ID_W_MAX   = 8;
    localparam int UPDATE_W   = 32;
    localparam int STATE_W    = 32;
    localparam int APB_ADDR_W = 8;

    // Context of one update request
    typedef enum logic [1:0] {
        UPDATE_CTXT_NOP      = 2'd0,
        UPDATE_CTXT_DATAPATH = 2'd1,
        UPDATE_CTXT_CONTROL  = 2'd2,
        UPDATE_CTXT_REAP     = 2'd3
    } update_ctxt_t;

    // One request towards the counter bank
    typedef struct packed {
        logic                  req;
        update_ctxt_t          ctxt;
        logic [ID_W_MAX-1:0]   id;
        logic                  init;
        logic [UPDATE_W-1:0]   update;
    } state_req_t;

    // Response, returns the state held before the update
    typedef struct packed {
        logic                  ack;
        logic [STATE_W-1:0]    state;
    } state_resp_t;

    // APB register map
    localparam logic [APB_ADDR_W-1:0] REG_CMD    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_DATA   = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_RESULT = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h0C;

endpackage : state_pkg
